// File: src/translator_pkg.sv
// widths, vector typedefs and wait-counter width for the avalon slave translator
`default_nettype none

package translator_pkg;

   // --------------------------------------------------------------------------
   // data path
   // --------------------------------------------------------------------------
   localparam int DATA_W           = 32;
   localparam int SYMBOLS_PER_WORD = 4;   // bytes per word
   localparam int WORD_SHIFT       = 2;   // log2 of symbols per word

   // --------------------------------------------------------------------------
   // address and burst
   // --------------------------------------------------------------------------
   localparam int UAV_ADDR_W  = 16;                       // byte address
   localparam int AV_ADDR_W   = UAV_ADDR_W - WORD_SHIFT;  // word address
   localparam int UAV_BURST_W = 7;                        // up to 64 bytes
   localparam int AV_BURST_W  = UAV_BURST_W - WORD_SHIFT; // up to 16 words

   // wait-state counter for commands of up to 15 cycles
   localparam int CNT_W = 4;

   // --------------------------------------------------------------------------
   // vector types
   // --------------------------------------------------------------------------
   typedef logic [DATA_W-1:0]           data_t;
   typedef logic [SYMBOLS_PER_WORD-1:0] byteen_t;

   typedef logic [UAV_ADDR_W-1:0]       uav_addr_t;
   typedef logic [AV_ADDR_W-1:0]        av_addr_t;

   typedef logic [UAV_BURST_W-1:0]      uav_burst_t;
   typedef logic [AV_BURST_W-1:0]       av_burst_t;

   typedef logic [CNT_W-1:0]            wait_cnt_t;

endpackage : translator_pkg

`default_nettype wire

// File: src/translator_decode.sv
// byte to word address and burstcount conversion, byteenables and write-burst tracking
`timescale 1ns/1ps
`default_nettype none

module translator_decode
   import translator_pkg::*;
(
   input  wire        clk,
   input  wire        reset,

   // upstream command
   input  uav_addr_t  uav_address,
   input  uav_burst_t uav_burstcount,
   input  byteen_t    uav_byteenable,
   input  data_t      uav_writedata,
   input  wire        uav_read,
   input  wire        uav_write,

   // from the wait timer
   input  wire        av_begintransfer,
   input  wire        write_accept,

   // downstream command
   output av_addr_t   av_address,
   output av_burst_t  av_burstcount,
   output byteen_t    av_byteenable,
   output byteen_t    av_writebyteenable,
   output data_t      av_writedata,
   output logic       av_beginbursttransfer
);

   av_burst_t beats_left;    // write beats still to come in this burst
   logic      burst_active;

   // ---------------------------------------------------------------------------
   // address and burstcount in word units
   // ---------------------------------------------------------------------------
   assign av_address    = uav_address[UAV_ADDR_W-1:WORD_SHIFT];
   assign av_burstcount = uav_burstcount[UAV_BURST_W-1:WORD_SHIFT]; // low bits dropped

   assign av_byteenable      = uav_byteenable;
   assign av_writebyteenable = uav_byteenable & {SYMBOLS_PER_WORD{uav_write}};
   assign av_writedata       = uav_writedata;

   // ---------------------------------------------------------------------------
   // write-burst tracking
   // ---------------------------------------------------------------------------
   assign burst_active = (beats_left != '0);

   // each write beat is its own command and the first one sets the count
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         beats_left <= '0;
      end else if (write_accept) begin
         if (burst_active) begin
            beats_left <= beats_left - 1'b1;
         end else if (av_burstcount > av_burst_t'(1)) begin
            beats_left <= av_burstcount - 1'b1;   // first beat already done
         end else begin
            beats_left <= '0;                     // single-beat write
         end
      end
   end

   // reads always start a burst, writes only on their first beat
   always_comb begin
      if (uav_read) begin
         av_beginbursttransfer = av_begintransfer;
      end else begin
         av_beginbursttransfer = av_begintransfer & uav_write & ~burst_active;
      end
   end

endmodule : translator_decode

`default_nettype wire

// File: src/translator_wait_timer.sv
// wait-state counter for av_read, av_write, waitrequest and begintransfer
`timescale 1ns/1ps
`default_nettype none

module translator_wait_timer
   import translator_pkg::*;
#(
   parameter int SETUP_CYCLES      = 1,
   parameter int READ_WAIT_CYCLES  = 1,
   parameter int WRITE_WAIT_CYCLES = 2,
   parameter int HOLD_CYCLES       = 1
) (
   input  wire  clk,
   input  wire  reset,

   input  wire  uav_read,
   input  wire  uav_write,

   output logic av_read,
   output logic av_write,
   output logic uav_waitrequest,
   output logic av_begintransfer,
   output logic read_accept,
   output logic write_accept
);

   // ---------------------------------------------------------------------------
   // cycle numbers within one command counted from 0
   // ---------------------------------------------------------------------------
   localparam wait_cnt_t SETUP_END = wait_cnt_t'(SETUP_CYCLES);
   localparam wait_cnt_t READ_DONE = wait_cnt_t'(SETUP_CYCLES + READ_WAIT_CYCLES);
   localparam wait_cnt_t WRITE_END = wait_cnt_t'(SETUP_CYCLES + WRITE_WAIT_CYCLES);
   localparam wait_cnt_t WRITE_DONE =
      wait_cnt_t'(SETUP_CYCLES + WRITE_WAIT_CYCLES + HOLD_CYCLES);

   wait_cnt_t wait_cnt;
   logic      reset_override;   // one cycle of forced waitrequest
   logic      cmd_pending;
   logic      wait_gen;

   assign cmd_pending = uav_read | uav_write;

   // ---------------------------------------------------------------------------
   // counter
   // ---------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         reset_override <= 1'b1;
         wait_cnt       <= '0;
      end else begin
         reset_override <= 1'b0;
         if (~uav_waitrequest | reset_override) begin
            wait_cnt <= '0;                       // accepted so the next command starts over
         end else if (cmd_pending) begin
            wait_cnt <= wait_cnt + 1'b1;
         end else begin
            wait_cnt <= '0;
         end
      end
   end

   // ---------------------------------------------------------------------------
   // strobes and waitrequest
   // ---------------------------------------------------------------------------

   // write window ends before the hold cycles
   always_comb begin
      av_read  = uav_read & ~reset_override & (wait_cnt >= SETUP_END);
      av_write = uav_write & ~reset_override & (wait_cnt >= SETUP_END)
                 & (wait_cnt <= WRITE_END);
   end

   always_comb begin
      if (uav_write) begin
         wait_gen = (wait_cnt != WRITE_DONE);
      end else begin
         wait_gen = (wait_cnt != READ_DONE);
      end
      uav_waitrequest = wait_gen | reset_override;
   end

   // first cycle of every command only
   assign av_begintransfer = cmd_pending & ~reset_override & (wait_cnt == '0);

   assign read_accept  = uav_read & ~uav_waitrequest;
   assign write_accept = uav_write & ~uav_waitrequest;

endmodule : translator_wait_timer

`default_nettype wire

// File: src/translator_read_return.sv
// read-latency pipeline, readdatavalid, readdata and chipselect
`timescale 1ns/1ps
`default_nettype none

module translator_read_return
   import translator_pkg::*;
#(
   parameter int READ_LATENCY = 2    // at least 1
) (
   input  wire   clk,
   input  wire   reset,

   input  wire   read_accept,
   input  wire   uav_read,
   input  wire   uav_write,
   input  data_t av_readdata,

   output logic  uav_readdatavalid,
   output data_t uav_readdata,
   output logic  av_chipselect
);

   // one bit per latency cycle and bit 0 is the cycle after accept
   logic [READ_LATENCY-1:0] rd_pipe;

   // ---------------------------------------------------------------------------
   // latency pipeline
   // ---------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rd_pipe <= '0;
      end else begin
         rd_pipe[0] <= read_accept;
         for (int i = 1; i < READ_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
         end
      end
   end

   assign uav_readdatavalid = rd_pipe[READ_LATENCY-1];

   // peripheral data is only meaningful in the valid cycle
   assign uav_readdata = uav_readdatavalid ? av_readdata : '0;

   // ---------------------------------------------------------------------------
   // chipselect
   // ---------------------------------------------------------------------------
   // stays up until the last read in flight has returned
   assign av_chipselect = uav_read | uav_write | (|rd_pipe);

endmodule : translator_read_return

`default_nettype wire

// File: src/avalon_slave_translator.sv
// top level with timing parameters, decode, wait timer and read return
`timescale 1ns/1ps
`default_nettype none

module avalon_slave_translator
   import translator_pkg::*;
#(
   parameter int SETUP_CYCLES      = 1,
   parameter int READ_WAIT_CYCLES  = 1,
   parameter int WRITE_WAIT_CYCLES = 2,
   parameter int HOLD_CYCLES       = 1,
   parameter int READ_LATENCY      = 2
) (
   input  wire        clk,
   input  wire        reset,

   // ---------------------------------------------------------------------------
   // universal avalon slave side with byte addresses
   // ---------------------------------------------------------------------------
   input  uav_addr_t  uav_address,
   input  data_t      uav_writedata,
   input  wire        uav_read,
   input  wire        uav_write,
   input  uav_burst_t uav_burstcount,
   input  byteen_t    uav_byteenable,

   output logic       uav_waitrequest,
   output data_t      uav_readdata,
   output logic       uav_readdatavalid,

   // ---------------------------------------------------------------------------
   // avalon mm master side with word addresses and fixed timing
   // ---------------------------------------------------------------------------
   output av_addr_t   av_address,
   output data_t      av_writedata,
   output logic       av_read,
   output logic       av_write,
   output av_burst_t  av_burstcount,
   output byteen_t    av_byteenable,
   output byteen_t    av_writebyteenable,
   output logic       av_begintransfer,
   output logic       av_beginbursttransfer,
   output logic       av_chipselect,

   input  data_t      av_readdata
);

   logic read_accept;    // command taken this cycle
   logic write_accept;

   translator_decode u_decode (
      .clk                   (clk),
      .reset                 (reset),
      .uav_address           (uav_address),
      .uav_burstcount        (uav_burstcount),
      .uav_byteenable        (uav_byteenable),
      .uav_writedata         (uav_writedata),
      .uav_read              (uav_read),
      .uav_write             (uav_write),
      .av_begintransfer      (av_begintransfer),
      .write_accept          (write_accept),
      .av_address            (av_address),
      .av_burstcount         (av_burstcount),
      .av_byteenable         (av_byteenable),
      .av_writebyteenable    (av_writebyteenable),
      .av_writedata          (av_writedata),
      .av_beginbursttransfer (av_beginbursttransfer)
   );

   translator_wait_timer #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES)
   ) u_wait_timer (
      .clk              (clk),
      .reset            (reset),
      .uav_read         (uav_read),
      .uav_write        (uav_write),
      .av_read          (av_read),
      .av_write         (av_write),
      .uav_waitrequest  (uav_waitrequest),
      .av_begintransfer (av_begintransfer),
      .read_accept      (read_accept),
      .write_accept     (write_accept)
   );

   translator_read_return #(
      .READ_LATENCY (READ_LATENCY)
   ) u_read_return (
      .clk               (clk),
      .reset             (reset),
      .read_accept       (read_accept),
      .uav_read          (uav_read),
      .uav_write         (uav_write),
      .av_readdata       (av_readdata),
      .uav_readdatavalid (uav_readdatavalid),
      .uav_readdata      (uav_readdata),
      .av_chipselect     (av_chipselect)
   );

endmodule : avalon_slave_translator

`default_nettype wire

// File: dv/tb_translator_asserts.sv
// concurrent checks on write strobe, burst start and read latency
`timescale 1ns/1ps
`default_nettype none

module tb_translator_asserts #(
   parameter int READ_LATENCY = 2
) (
   input wire clk,
   input wire reset,
   input wire uav_read,
   input wire uav_write,
   input wire uav_waitrequest,
   input wire uav_readdatavalid,
   input wire av_write,
   input wire av_begintransfer,
   input wire av_beginbursttransfer
);

   int unsigned fail_count = 0;   // read by the testbench at the end
   logic        read_taken;

   assign read_taken = uav_read & ~uav_waitrequest;

   // --------------------------------------------------------------------------
   // strobes
   // --------------------------------------------------------------------------
   write_needs_command: assert property (@(posedge clk) disable iff (reset)
      av_write |-> uav_write)
      else begin
         fail_count = fail_count + 1;
         $error("av_write high without uav_write");
      end

   burst_start_on_transfer: assert property (@(posedge clk) disable iff (reset)
      av_beginbursttransfer |-> av_begintransfer)
      else begin
         fail_count = fail_count + 1;
         $error("beginbursttransfer alone");
      end

   // --------------------------------------------------------------------------
   // read return latency in both directions
   // --------------------------------------------------------------------------
   valid_after_read: assert property (@(posedge clk) disable iff (reset)
      read_taken |-> ##READ_LATENCY uav_readdatavalid)
      else begin
         fail_count = fail_count + 1;
         $error("readdatavalid missing");
      end

   valid_only_for_read: assert property (@(posedge clk) disable iff (reset)
      uav_readdatavalid |-> $past(read_taken, READ_LATENCY))
      else begin
         fail_count = fail_count + 1;
         $error("readdatavalid without a read");
      end

endmodule : tb_translator_asserts

`default_nettype wire

// File: dv/tb_translator.sv
// clock, reset, peripheral model, directed tests, check task and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_translator
   import translator_pkg::*;
();

   localparam int SETUP      = 1;
   localparam int READ_WAIT  = 1;
   localparam int WRITE_WAIT = 2;
   localparam int HOLD       = 1;
   localparam int RD_LAT     = 2;
   localparam int READ_DONE  = SETUP + READ_WAIT;    // accept cycle of a read
   localparam int WRITE_END  = SETUP + WRITE_WAIT;   // last av_write cycle
   localparam int WRITE_DONE = WRITE_END + HOLD;     // accept cycle of a write
   localparam int CLK_PERIOD = 8;
   localparam int NUM_TESTS  = 6;

   logic       clk = 1'b0;
   logic       reset;
   uav_addr_t  uav_address;
   data_t      uav_writedata;
   logic       uav_read;
   logic       uav_write;
   uav_burst_t uav_burstcount;
   byteen_t    uav_byteenable;
   logic       uav_waitrequest;
   data_t      uav_readdata;
   logic       uav_readdatavalid;
   av_addr_t   av_address;
   data_t      av_writedata;
   logic       av_read;
   logic       av_write;
   av_burst_t  av_burstcount;
   byteen_t    av_byteenable;
   byteen_t    av_writebyteenable;
   logic       av_begintransfer;
   logic       av_beginbursttransfer;
   logic       av_chipselect;
   data_t      av_readdata;

   data_t      mem [64];              // peripheral storage
   data_t      ref_mem [64];          // expected contents
   logic [5:0] rd_addr_pipe [RD_LAT];
   data_t      exp_data_q [$];
   int         exp_cycle_q [$];       // cycle in which each read must return
   int         cycle_cnt = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   avalon_slave_translator dut (.*);

   bind avalon_slave_translator tb_translator_asserts #(.READ_LATENCY(READ_LATENCY)) u_asserts (
      .clk(clk), .reset(reset), .uav_read(uav_read), .uav_write(uav_write),
      .uav_waitrequest(uav_waitrequest), .uav_readdatavalid(uav_readdatavalid),
      .av_write(av_write), .av_begintransfer(av_begintransfer),
      .av_beginbursttransfer(av_beginbursttransfer)
   );

   // --------------------------------------------------------------------------
   // fixed-timing peripheral without back-pressure
   // --------------------------------------------------------------------------
   always @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 64; i++) begin
            mem[i] <= 32'h5a00_0000 + i * 32'h0001_0101;
         end
         for (int i = 0; i < RD_LAT; i++) begin
            rd_addr_pipe[i] <= '0;
         end
      end else begin
         if (av_write) begin
            for (int b = 0; b < SYMBOLS_PER_WORD; b++) begin
               if (av_writebyteenable[b]) begin
                  mem[av_address[5:0]][8*b +: 8] <= av_writedata[8*b +: 8];
               end
            end
         end
         if (av_read && !uav_waitrequest) rd_addr_pipe[0] <= av_address[5:0];  // accepted read
         for (int i = 1; i < RD_LAT; i++) begin
            rd_addr_pipe[i] <= rd_addr_pipe[i-1];
         end
      end
   end

   assign av_readdata = mem[rd_addr_pipe[RD_LAT-1]];

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // --------------------------------------------------------------------------
   // helpers
   // --------------------------------------------------------------------------
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("FAILED at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
         $display("test failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   function automatic data_t merge_bytes(data_t old_word, data_t new_word, byteen_t be);
      data_t result;
      result = old_word;
      for (int b = 0; b < SYMBOLS_PER_WORD; b++) begin
         if (be[b]) result[8*b +: 8] = new_word[8*b +: 8];
      end
      return result;
   endfunction

   function automatic uav_addr_t random_word_addr();
      return uav_addr_t'($urandom_range(0, 63) << WORD_SHIFT);
   endfunction

   // read return is checked every cycle against the queue of expected words
   always @(negedge clk) begin
      if (!reset && exp_cycle_q.size() != 0) begin
         check_value("av_chipselect", 1, av_chipselect);
         if (exp_cycle_q[0] == cycle_cnt) begin
            check_value("uav_readdatavalid", 1, uav_readdatavalid);
            check_value("uav_readdata", exp_data_q[0], uav_readdata);
            void'(exp_data_q.pop_front());
            void'(exp_cycle_q.pop_front());
         end else begin
            check_value("uav_readdatavalid", 0, uav_readdatavalid);
         end
      end else if (!reset) begin
         check_value("uav_readdatavalid", 0, uav_readdatavalid);
      end
   end

   task automatic write_cmd(input uav_addr_t addr, input data_t data, input byteen_t be,
                            input uav_burst_t burst, input logic first_beat);
      int   n;
      logic done;
      @(posedge clk);
      #1;
      uav_address    = addr;
      uav_writedata  = data;
      uav_byteenable = be;
      uav_burstcount = burst;
      uav_read       = 1'b0;
      uav_write      = 1'b1;
      n    = 0;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         check_value("uav_waitrequest", n != WRITE_DONE, uav_waitrequest);
         check_value("av_write", (n >= SETUP) && (n <= WRITE_END), av_write);
         check_value("av_read", 0, av_read);
         check_value("av_begintransfer", n == 0, av_begintransfer);
         check_value("av_beginbursttransfer", (n == 0) && first_beat, av_beginbursttransfer);
         check_value("av_address", addr >> WORD_SHIFT, av_address);
         check_value("av_burstcount", burst >> WORD_SHIFT, av_burstcount);
         check_value("av_writedata", data, av_writedata);
         check_value("av_byteenable", be, av_byteenable);
         check_value("av_writebyteenable", be, av_writebyteenable);
         check_value("av_chipselect", 1, av_chipselect);
         done = !uav_waitrequest;
         n++;
      end
      ref_mem[addr[7:2]] = merge_bytes(ref_mem[addr[7:2]], data, be);
   endtask

   task automatic read_cmd(input uav_addr_t addr);
      int   n;
      logic done;
      @(posedge clk);
      #1;
      uav_address    = addr;
      uav_byteenable = 4'hf;
      uav_burstcount = 7'd4;
      uav_write      = 1'b0;
      uav_read       = 1'b1;
      n    = 0;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         check_value("uav_waitrequest", n != READ_DONE, uav_waitrequest);
         check_value("av_read", n >= SETUP, av_read);
         check_value("av_write", 0, av_write);
         check_value("av_begintransfer", n == 0, av_begintransfer);
         check_value("av_beginbursttransfer", n == 0, av_beginbursttransfer);
         check_value("av_address", addr >> WORD_SHIFT, av_address);
         check_value("av_byteenable", 4'hf, av_byteenable);
         check_value("av_writebyteenable", 0, av_writebyteenable);
         done = !uav_waitrequest;
         n++;
      end
      exp_data_q.push_back(ref_mem[addr[7:2]]);
      exp_cycle_q.push_back(cycle_cnt + RD_LAT);
   endtask

   task automatic go_idle();
      @(posedge clk);
      #1;
      uav_read  = 1'b0;
      uav_write = 1'b0;
   endtask

   task automatic wait_reads_returned();
      while (exp_cycle_q.size() != 0) @(negedge clk);
      @(negedge clk);
      check_value("av_chipselect", 0, av_chipselect);   // pipeline empty again
   endtask

   // --------------------------------------------------------------------------
   // directed tests
   // --------------------------------------------------------------------------
   task automatic reset_values();
      @(negedge clk);
      check_value("uav_waitrequest", 1, uav_waitrequest);
      check_value("av_read", 0, av_read);
      check_value("av_write", 0, av_write);
      check_value("uav_readdatavalid", 0, uav_readdatavalid);
      check_value("av_chipselect", 0, av_chipselect);
   endtask

   task automatic write_timing(input uav_addr_t addr);
      write_cmd(addr, $urandom, 4'hf, 7'd4, 1'b1);
      go_idle();
   endtask

   task automatic read_timing(input uav_addr_t addr);
      read_cmd(addr);
      go_idle();
      wait_reads_returned();
   endtask

   task automatic back_to_back_reads();
      read_cmd(random_word_addr());
      read_cmd(random_word_addr());
      go_idle();
      wait_reads_returned();
   endtask

   task automatic partial_writes();
      uav_addr_t addr;
      addr = random_word_addr();
      write_cmd(addr, $urandom, 4'b0101, 7'd4, 1'b1);
      write_cmd(addr, $urandom, 4'b1000, 7'd4, 1'b1);
      read_cmd(addr);
      go_idle();
      wait_reads_returned();
   endtask

   task automatic write_burst();
      uav_addr_t addr;
      addr = random_word_addr();
      for (int beat = 0; beat < 4; beat++) begin
         write_cmd(addr, $urandom, 4'hf, 7'd16, beat == 0);   // address held over the burst
      end
      write_cmd(addr + 16'd4, $urandom, 4'hf, 7'd4, 1'b1);
      read_cmd(addr);
      go_idle();
      wait_reads_returned();
   endtask

   initial begin
      uav_addr_t addr;
      void'($urandom(40));
      reset          = 1'b1;
      uav_address    = '0;
      uav_writedata  = '0;
      uav_read       = 1'b0;
      uav_write      = 1'b0;
      uav_burstcount = '0;
      uav_byteenable = '0;
      for (int i = 0; i < 64; i++) begin
         ref_mem[i] = 32'h5a00_0000 + i * 32'h0001_0101;
      end
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
      reset_values();
      addr = random_word_addr();
      write_timing(addr);
      read_timing(addr);
      back_to_back_reads();
      partial_writes();
      write_burst();
      repeat (2) @(posedge clk);
      if (dut.u_asserts.fail_count == 0) begin
         $display("test passed");
         $finish;
      end else begin
         $display("test failed");
         $fatal(1, "concurrent assertions reported errors");
      end
   end

   // watchdog
   initial begin
      #(NUM_TESTS * 200 * CLK_PERIOD);
      $display("watchdog expired, tests still running after %0d cycles", NUM_TESTS * 200);
      $display("test failed");
      $fatal(1, "timeout");
   end

endmodule : tb_translator

`default_nettype wire

// File: vlog.f
src/translator_pkg.sv
src/translator_decode.sv
src/translator_wait_timer.sv
src/translator_read_return.sv
src/avalon_slave_translator.sv
dv/tb_translator_asserts.sv
dv/tb_translator.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the translator testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f vlog.f --top-module tb_translator -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vtb_translator)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "test passed"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
